// File: src.f
+incdir+test
hdl/fu_pkg.sv
hdl/fu_main.sv
hdl/fu_alu.sv
hdl/fu_br.sv
hdl/fu_mult.sv
hdl/fu_exec_top.sv
test/fu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module fu_tb -f src.f --Mdir obj_dir -o fu_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/fu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qxF '** PASS **'; then
	exit 0
fi
exit 1

// File: test/fu_tb_ref.svh
`ifndef FU_TB_REF_SVH
`define FU_TB_REF_SVH

function automatic logic [63:0] alu_ref(input alu_func_e func, input logic [63:0] a,
		input logic [63:0] b);
	case (func)
		ADD:     return a + b;
		SUB:     return a - b;
		AND:     return a & b;
		OR:      return a | b;
		XOR:     return a ^ b;
		SLL:     return a << b[5:0];
		SRL:     return a >> b[5:0];
		default: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
	endcase
endfunction

// low half of the full product
function automatic logic [63:0] mult_ref(input logic [63:0] a, input logic [63:0] b);
	return a * b;
endfunction

function automatic logic br_ref(input br_cond_e cond, input logic [63:0] a);
	case (cond)
		BR_ALWAYS: return 1'b1;
		BR_EQZ:    return a == 64'd0;
		BR_NEZ:    return a != 64'd0;
		BR_LTZ:    return a[63];
		BR_GEZ:    return !a[63];
		default:   return 1'b0;
	endcase
endfunction

function automatic logic [63:0] br_target_ref(input logic [63:0] npc, input logic [31:0] inst);
	logic signed [63:0] disp;
	// signed word count
	disp = $signed(inst[20:0]);
	return npc + disp * 4;
endfunction

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
	if (got !== exp) begin
		$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		value_errs++;
	end
endtask

task automatic check_tag(input string name, input logic [PRF_IDX_W-1:0] got,
		input logic [PRF_IDX_W-1:0] exp);
	if (got !== exp) begin
		$display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		tag_errs++;
	end
endtask

task automatic check_taken(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
		flag_errs++;
	end
endtask

`endif

// File: test/fu_tb.sv
module fu_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import fu_pkg::*;

	localparam int ROB_IDX_W   = DEF_ROB_IDX_W;
	localparam int PRF_IDX_W   = DEF_PRF_IDX_W;
	localparam int MULT_STAGES = DEF_MULT_STAGES;
	localparam int ROB_N       = 1 << ROB_IDX_W;

	logic                 clk;
	logic                 rst;
	logic                 iss_vld_i;
	fu_sel_e              fu_sel_i;
	logic [31:0]          inst_i;
	logic [63:0]          opa_i;
	logic [63:0]          opb_i;
	logic [63:0]          npc_i;
	logic [PRF_IDX_W-1:0] dest_tag_i;
	logic [ROB_IDX_W-1:0] rob_idx_i;
	logic                 recovery_i;
	logic                 cdb_vld_o;
	logic [PRF_IDX_W-1:0] cdb_tag_o;
	logic [63:0]          cdb_value_o;
	logic                 rob_done_o;
	logic [ROB_IDX_W-1:0] rob_idx_o;
	logic                 rob_br_taken_o;
	logic [63:0]          rob_br_target_o;
	logic                 bp_done_o;
	logic [63:0]          bp_pc_o;
	logic                 bp_taken_o;

	int value_errs = 0;
	int tag_errs   = 0;
	int flag_errs  = 0;
	int other_errs = 0;
	int cyc        = 0;

	// scoreboard with one entry per rob index
	fu_sel_e              kind      [ROB_N];
	logic [63:0]          exp_value [ROB_N];
	logic [PRF_IDX_W-1:0] exp_tag   [ROB_N];
	logic                 exp_taken [ROB_N];
	logic [63:0]          exp_pc    [ROB_N];
	logic                 pending   [ROB_N];
	int                   issue_cyc [ROB_N];
	logic [ROB_IDX_W-1:0] next_idx;

	`include "fu_tb_ref.svh"

	fu_exec_top dut_i (
		.clk (clk), .rst (rst), .iss_vld_i (iss_vld_i), .fu_sel_i (fu_sel_i),
		.inst_i (inst_i), .opa_i (opa_i), .opb_i (opb_i), .npc_i (npc_i),
		.dest_tag_i (dest_tag_i), .rob_idx_i (rob_idx_i), .recovery_i (recovery_i),
		.cdb_vld_o (cdb_vld_o), .cdb_tag_o (cdb_tag_o), .cdb_value_o (cdb_value_o),
		.rob_done_o (rob_done_o), .rob_idx_o (rob_idx_o),
		.rob_br_taken_o (rob_br_taken_o), .rob_br_target_o (rob_br_target_o),
		.bp_done_o (bp_done_o), .bp_pc_o (bp_pc_o), .bp_taken_o (bp_taken_o)
	);

	always #2 clk = ~clk;

	function automatic logic [63:0] rand64();
		return {$urandom, $urandom};
	endfunction

	function automatic logic mult_busy();
		for (int i = 0; i < ROB_N; i++) begin
			if (pending[i] && kind[i] == FU_SEL_MULT)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	function automatic logic [PRF_IDX_W-1:0] rand_tag();
		// now and then no destination
		if ($urandom_range(15, 0) == 0)
			return '0;
		return PRF_IDX_W'($urandom_range(63, 1));
	endfunction

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			iss_vld_i <= 1'b0;
			fu_sel_i  <= FU_SEL_NONE;
		end
	endtask

	task automatic alloc_idx(output logic [ROB_IDX_W-1:0] idx);
		int waited;
		waited = 0;
		while (pending[next_idx] && waited < 200) begin
			idle(1);
			waited++;
		end
		if (waited >= 200) begin
			$display("timeout: ROB index %0d never completed", next_idx);
			other_errs++;
		end
		idx = next_idx;
		next_idx = next_idx + ROB_IDX_W'(1);
	endtask

	task automatic wait_drain();
		int waited;
		logic busy;
		waited = 0;
		busy = 1'b1;
		while (busy && waited < 200) begin
			busy = 1'b0;
			for (int i = 0; i < ROB_N; i++)
				busy = busy | pending[i];
			if (busy) begin
				idle(1);
				waited++;
			end
		end
		if (busy) begin
			$display("timeout: operations still in flight after 200 cycles");
			other_errs++;
		end
	endtask

	task automatic drive(input fu_sel_e sel, input logic [31:0] inst, input logic [63:0] a,
			input logic [63:0] b, input logic [63:0] npc, input logic [PRF_IDX_W-1:0] tag,
			input logic [ROB_IDX_W-1:0] idx);
		@(posedge clk);
		pending[idx] = 1'b1;
		iss_vld_i  <= 1'b1;
		fu_sel_i   <= sel;
		inst_i     <= inst;
		opa_i      <= a;
		opb_i      <= b;
		npc_i      <= npc;
		dest_tag_i <= tag;
		rob_idx_i  <= idx;
	endtask

	task automatic issue_alu(input alu_func_e func);
		logic [ROB_IDX_W-1:0] idx;
		logic [63:0]          a;
		logic [63:0]          b;
		logic [31:0]          inst;
		alloc_idx(idx);
		a = rand64();
		b = rand64();
		inst = $urandom;
		inst[7:5] = func;
		kind[idx] = FU_SEL_ALU;
		exp_value[idx] = alu_ref(func, a, b);
		exp_tag[idx] = rand_tag();
		drive(FU_SEL_ALU, inst, a, b, rand64(), exp_tag[idx], idx);
	endtask

	task automatic issue_mult();
		logic [ROB_IDX_W-1:0] idx;
		logic [63:0]          a;
		logic [63:0]          b;
		alloc_idx(idx);
		a = rand64();
		b = rand64();
		kind[idx] = FU_SEL_MULT;
		exp_value[idx] = mult_ref(a, b);
		exp_tag[idx] = rand_tag();
		drive(FU_SEL_MULT, $urandom, a, b, rand64(), exp_tag[idx], idx);
	endtask

	task automatic issue_branch(input br_cond_e cond);
		logic [ROB_IDX_W-1:0] idx;
		logic [63:0]          a;
		logic [63:0]          npc;
		logic [31:0]          inst;
		alloc_idx(idx);
		case ($urandom_range(3, 0))
			0:       a = 64'd0;
			1:       a = rand64() | 64'h8000_0000_0000_0000;
			default: a = rand64();
		endcase
		npc = rand64();
		npc[1:0] = 2'b00;
		inst = $urandom;
		inst[28:26] = cond;
		kind[idx] = FU_SEL_BR;
		exp_taken[idx] = br_ref(cond, a);
		exp_value[idx] = br_target_ref(npc, inst);
		exp_pc[idx] = npc - 64'd4;
		drive(FU_SEL_BR, inst, a, rand64(), npc, '0, idx);
	endtask

	// checker samples mid-cycle
	always @(negedge clk) begin
		if (!rst) begin
			cyc++;
			if (iss_vld_i)
				issue_cyc[rob_idx_i] = cyc;
			if (rob_done_o) begin
				if (!pending[rob_idx_o]) begin
					$display("completion for ROB index %0d with nothing in flight at %0t ns",
						rob_idx_o, $time);
					other_errs++;
				end else if (kind[rob_idx_o] == FU_SEL_BR) begin
					if (cyc - issue_cyc[rob_idx_o] != 1) begin
						$display("branch %0d completed %0d cycles after issue", rob_idx_o,
							cyc - issue_cyc[rob_idx_o]);
						other_errs++;
					end
					check_taken("bp_done_o", bp_done_o, 1'b1);
					check_taken("rob_br_taken_o", rob_br_taken_o, exp_taken[rob_idx_o]);
					check_taken("bp_taken_o", bp_taken_o, exp_taken[rob_idx_o]);
					check_value("rob_br_target_o", rob_br_target_o, exp_value[rob_idx_o]);
					check_value("bp_pc_o", bp_pc_o, exp_pc[rob_idx_o]);
					check_taken("cdb_vld_o", cdb_vld_o, 1'b0);
				end else begin
					if (kind[rob_idx_o] == FU_SEL_ALU ? cyc - issue_cyc[rob_idx_o] != 1
							: cyc - issue_cyc[rob_idx_o] < MULT_STAGES) begin
						$display("op %0d completed %0d cycles after issue", rob_idx_o,
							cyc - issue_cyc[rob_idx_o]);
						other_errs++;
					end
					// dropped from the cdb when presented during recovery
					check_taken("cdb_vld_o", cdb_vld_o,
						!recovery_i && exp_tag[rob_idx_o] != '0);
					if (!recovery_i && exp_tag[rob_idx_o] != '0) begin
						check_tag("cdb_tag_o", cdb_tag_o, exp_tag[rob_idx_o]);
						check_value("cdb_value_o", cdb_value_o, exp_value[rob_idx_o]);
					end
					check_taken("bp_done_o", bp_done_o, 1'b0);
				end
				pending[rob_idx_o] = 1'b0;
			end else begin
				check_taken("cdb_vld_o", cdb_vld_o, 1'b0);
				check_taken("bp_done_o", bp_done_o, 1'b0);
			end
			if (recovery_i) begin
				for (int i = 0; i < ROB_N; i++) begin
					if (kind[i] != FU_SEL_BR)
						pending[i] = 1'b0;
				end
			end
		end
	end

	initial begin
		int pick;
		clk        = 1'b0;
		rst        = 1'b1;
		iss_vld_i  = 1'b0;
		fu_sel_i   = FU_SEL_NONE;
		inst_i     = '0;
		opa_i      = '0;
		opb_i      = '0;
		npc_i      = '0;
		dest_tag_i = '0;
		rob_idx_i  = '0;
		recovery_i = 1'b0;
		next_idx   = '0;
		for (int i = 0; i < ROB_N; i++) begin
			pending[i] = 1'b0;
			kind[i] = FU_SEL_NONE;
		end
		void'($urandom(32'h55e9));
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		// quiet after reset
		repeat (5) begin
			@(negedge clk);
			check_taken("rob_done_o", rob_done_o, 1'b0);
			check_taken("bp_taken_o", bp_taken_o, 1'b0);
			check_taken("rob_br_taken_o", rob_br_taken_o, 1'b0);
			check_taken("mult_stall", dut_i.mult_stall, 1'b0);
		end

		for (int f = 0; f < 8; f++)
			repeat (4) issue_alu(alu_func_e'(3'(f)));
		for (int c = 0; c < 5; c++)
			repeat (3) issue_branch(br_cond_e'(3'(c)));
		wait_drain();

		repeat (MULT_STAGES) issue_mult();
		wait_drain();

		// alu and branch finishing with a multiply
		issue_mult();
		idle(MULT_STAGES - 2);
		issue_alu(ADD);
		idle(1);
		issue_mult();
		idle(MULT_STAGES - 2);
		issue_branch(BR_ALWAYS);
		wait_drain();

		// squash in-flight work
		repeat (3) issue_mult();
		issue_alu(XOR);
		@(posedge clk);
		iss_vld_i  <= 1'b0;
		fu_sel_i   <= FU_SEL_NONE;
		recovery_i <= 1'b1;
		@(posedge clk);
		recovery_i <= 1'b0;
		idle(MULT_STAGES + 4);
		issue_alu(SUB);
		issue_mult();
		issue_branch(BR_NEZ);
		wait_drain();

		repeat (200) begin
			pick = $urandom_range(2, 0);
			case (pick)
				0: issue_alu(alu_func_e'(3'($urandom_range(7, 0))));
				1: issue_branch(br_cond_e'(3'($urandom_range(4, 0))));
				default: issue_mult();
			endcase
			// gap after alu or branch so the multiplier drains
			if (pick != 2 && mult_busy())
				idle(1);
			if ($urandom_range(3, 0) == 0)
				idle(1);
		end
		wait_drain();
		idle(2);

		$display("errors: value %0d, tag %0d, flag %0d, other %0d",
			value_errs, tag_errs, flag_errs, other_errs);
		if (value_errs + tag_errs + flag_errs + other_errs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: hdl/fu_exec_top.sv
module fu_exec_top #(
	parameter int ROB_IDX_W   = fu_pkg::DEF_ROB_IDX_W,
	parameter int PRF_IDX_W   = fu_pkg::DEF_PRF_IDX_W,
	parameter int MULT_STAGES = fu_pkg::DEF_MULT_STAGES
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 iss_vld_i,
	input  fu_pkg::fu_sel_e      fu_sel_i,
	input  logic [31:0]          inst_i,
	input  logic [63:0]          opa_i,
	input  logic [63:0]          opb_i,
	input  logic [63:0]          npc_i,
	input  logic [PRF_IDX_W-1:0] dest_tag_i,
	input  logic [ROB_IDX_W-1:0] rob_idx_i,
	input  logic                 recovery_i,
	output logic                 cdb_vld_o,
	output logic [PRF_IDX_W-1:0] cdb_tag_o,
	output logic [63:0]          cdb_value_o,
	output logic                 rob_done_o,
	output logic [ROB_IDX_W-1:0] rob_idx_o,
	output logic                 rob_br_taken_o,
	output logic [63:0]          rob_br_target_o,
	output logic                 bp_done_o,
	output logic [63:0]          bp_pc_o,
	output logic                 bp_taken_o
);
	logic                 alu_start;
	logic                 br_start;
	logic                 mult_start;
	logic                 mult_stall;
	logic                 alu_done;
	logic [63:0]          alu_result;
	logic [PRF_IDX_W-1:0] alu_tag;
	logic [ROB_IDX_W-1:0] alu_rob;
	logic                 mult_done;
	logic [63:0]          mult_result;
	logic [PRF_IDX_W-1:0] mult_tag;
	logic [ROB_IDX_W-1:0] mult_rob;
	logic                 br_done;
	logic                 br_taken;
	logic [63:0]          br_target;
	logic [63:0]          br_pc;
	logic [ROB_IDX_W-1:0] br_rob;

	fu_main #(
		.ROB_IDX_W (ROB_IDX_W),
		.PRF_IDX_W (PRF_IDX_W)
	) fu_main_i (
		.clk (clk), .rst (rst),
		.iss_vld_i (iss_vld_i), .fu_sel_i (fu_sel_i), .recovery_i (recovery_i),
		.alu_done_i (alu_done), .alu_result_i (alu_result),
		.alu_tag_i (alu_tag), .alu_rob_i (alu_rob),
		.mult_done_i (mult_done), .mult_result_i (mult_result),
		.mult_tag_i (mult_tag), .mult_rob_i (mult_rob),
		.br_done_i (br_done), .br_taken_i (br_taken), .br_target_i (br_target),
		.br_pc_i (br_pc), .br_rob_i (br_rob),
		.alu_start_o (alu_start), .br_start_o (br_start),
		.mult_start_o (mult_start), .mult_stall_o (mult_stall),
		.cdb_vld_o (cdb_vld_o), .cdb_tag_o (cdb_tag_o), .cdb_value_o (cdb_value_o),
		.rob_done_o (rob_done_o), .rob_idx_o (rob_idx_o),
		.rob_br_taken_o (rob_br_taken_o), .rob_br_target_o (rob_br_target_o),
		.bp_done_o (bp_done_o), .bp_pc_o (bp_pc_o), .bp_taken_o (bp_taken_o)
	);

	fu_alu #(
		.ROB_IDX_W (ROB_IDX_W),
		.PRF_IDX_W (PRF_IDX_W)
	) fu_alu_i (
		.clk (clk), .rst (rst), .start_i (alu_start), .recovery_i (recovery_i),
		.opa_i (opa_i), .opb_i (opb_i), .inst_i (inst_i),
		.dest_tag_i (dest_tag_i), .rob_idx_i (rob_idx_i),
		.result_o (alu_result), .dest_tag_o (alu_tag),
		.rob_idx_o (alu_rob), .done_o (alu_done)
	);

	fu_br #(
		.ROB_IDX_W (ROB_IDX_W)
	) fu_br_i (
		.clk (clk), .rst (rst), .start_i (br_start),
		.opa_i (opa_i), .npc_i (npc_i), .inst_i (inst_i), .rob_idx_i (rob_idx_i),
		.done_o (br_done), .taken_o (br_taken), .target_o (br_target),
		.pc_o (br_pc), .rob_idx_o (br_rob)
	);

	// done_pre is not needed by the fixed-priority arbiter
	fu_mult #(
		.ROB_IDX_W   (ROB_IDX_W),
		.PRF_IDX_W   (PRF_IDX_W),
		.MULT_STAGES (MULT_STAGES)
	) fu_mult_i (
		.clk (clk), .rst (rst), .start_i (mult_start), .stall_i (mult_stall),
		.recovery_i (recovery_i), .opa_i (opa_i), .opb_i (opb_i),
		.dest_tag_i (dest_tag_i), .rob_idx_i (rob_idx_i),
		.product_o (mult_result), .dest_tag_o (mult_tag), .rob_idx_o (mult_rob),
		.done_pre_o (), .done_o (mult_done)
	);

endmodule

// File: hdl/fu_mult.sv
module fu_mult #(
	parameter int ROB_IDX_W   = fu_pkg::DEF_ROB_IDX_W,
	parameter int PRF_IDX_W   = fu_pkg::DEF_PRF_IDX_W,
	parameter int MULT_STAGES = fu_pkg::DEF_MULT_STAGES
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start_i,
	input  logic                 stall_i,
	input  logic                 recovery_i,
	input  logic [63:0]          opa_i,
	input  logic [63:0]          opb_i,
	input  logic [PRF_IDX_W-1:0] dest_tag_i,
	input  logic [ROB_IDX_W-1:0] rob_idx_i,
	output logic [63:0]          product_o,
	output logic [PRF_IDX_W-1:0] dest_tag_o,
	output logic [ROB_IDX_W-1:0] rob_idx_o,
	output logic                 done_pre_o,
	output logic                 done_o
);
	// multiplier bits consumed per stage
	localparam int CHUNK = 64 / MULT_STAGES;

	logic [63:0]          prod_in   [MULT_STAGES];
	logic [63:0]          mcand_in  [MULT_STAGES];
	logic [63:0]          mplier_in [MULT_STAGES];
	logic [63:0]          prod_q    [MULT_STAGES];
	logic [63:0]          mcand_q   [MULT_STAGES-1];
	logic [63:0]          mplier_q  [MULT_STAGES-1];
	logic [PRF_IDX_W-1:0] tag_q     [MULT_STAGES];
	logic [ROB_IDX_W-1:0] rob_q     [MULT_STAGES];
	logic [MULT_STAGES-1:0] vld_q;

	// add the partial products for the low CHUNK bits of the multiplier
	function automatic logic [63:0] add_chunk(input logic [63:0] acc,
			input logic [63:0] mcand, input logic [63:0] mplier);
		logic [63:0] sum;
		sum = acc;
		for (int i = 0; i < CHUNK; i++) begin
			if (mplier[i]) begin
				sum = sum + (mcand << i);
			end
		end
		return sum;
	endfunction

	// stage 0 takes the operands and later stages the previous stage
	always_comb begin
		prod_in[0]   = '0;
		mcand_in[0]  = opa_i;
		mplier_in[0] = opb_i;
		for (int s = 1; s < MULT_STAGES; s++) begin
			prod_in[s]   = prod_q[s-1];
			mcand_in[s]  = mcand_q[s-1];
			mplier_in[s] = mplier_q[s-1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst || recovery_i) begin
			vld_q <= '0;
		end else if (!stall_i) begin
			vld_q[0] <= start_i;
			for (int s = 1; s < MULT_STAGES; s++) begin
				vld_q[s] <= vld_q[s-1];
			end
		end
	end

	// whole pipe freezes on stall
	always_ff @(posedge clk) begin
		if (!stall_i) begin
			tag_q[0] <= dest_tag_i;
			rob_q[0] <= rob_idx_i;
			for (int s = 1; s < MULT_STAGES; s++) begin
				tag_q[s] <= tag_q[s-1];
				rob_q[s] <= rob_q[s-1];
			end
			for (int s = 0; s < MULT_STAGES; s++) begin
				prod_q[s] <= add_chunk(prod_in[s], mcand_in[s], mplier_in[s]);
			end
			for (int s = 0; s < MULT_STAGES - 1; s++) begin
				mcand_q[s]  <= mcand_in[s] << CHUNK;
				mplier_q[s] <= mplier_in[s] >> CHUNK;
			end
		end
	end

	assign product_o  = prod_q[MULT_STAGES-1];
	assign dest_tag_o = tag_q[MULT_STAGES-1];
	assign rob_idx_o  = rob_q[MULT_STAGES-1];
	assign done_o     = vld_q[MULT_STAGES-1];

	// result shown next cycle if it moves in or is held
	assign done_pre_o = stall_i ? vld_q[MULT_STAGES-1] : vld_q[MULT_STAGES-2];

endmodule

// File: hdl/fu_br.sv
module fu_br #(
	parameter int ROB_IDX_W = fu_pkg::DEF_ROB_IDX_W
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start_i,
	input  logic [63:0]          opa_i,
	input  logic [63:0]          npc_i,
	input  logic [31:0]          inst_i,
	input  logic [ROB_IDX_W-1:0] rob_idx_i,
	output logic                 done_o,
	output logic                 taken_o,
	output logic [63:0]          target_o,
	output logic [63:0]          pc_o,
	output logic [ROB_IDX_W-1:0] rob_idx_o
);
	import fu_pkg::*;

	br_cond_e    cond;
	logic        taken;
	logic [63:0] disp;

	assign cond = br_cond_e'(inst_i[28:26]);

	// word displacement, sign extended
	assign disp = {{41{inst_i[20]}}, inst_i[20:0], 2'b00};

	always_comb begin
		case (cond)
			BR_ALWAYS: taken = 1'b1;
			BR_EQZ:    taken = (opa_i == '0);
			BR_NEZ:    taken = (opa_i != '0);
			BR_LTZ:    taken = opa_i[63];
			BR_GEZ:    taken = ~opa_i[63];
			default:   taken = 1'b0;
		endcase
	end

	// no squash, the branch is older than any recovery it causes
	always_ff @(posedge clk) begin
		if (rst) begin
			done_o <= 1'b0;
		end else begin
			done_o <= start_i;
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			taken_o   <= taken;
			target_o  <= npc_i + disp;
			pc_o      <= npc_i - 64'd4;
			rob_idx_o <= rob_idx_i;
		end
	end

endmodule

// File: hdl/fu_alu.sv
module fu_alu #(
	parameter int ROB_IDX_W = fu_pkg::DEF_ROB_IDX_W,
	parameter int PRF_IDX_W = fu_pkg::DEF_PRF_IDX_W
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start_i,
	input  logic                 recovery_i,
	input  logic [63:0]          opa_i,
	input  logic [63:0]          opb_i,
	input  logic [31:0]          inst_i,
	input  logic [PRF_IDX_W-1:0] dest_tag_i,
	input  logic [ROB_IDX_W-1:0] rob_idx_i,
	output logic [63:0]          result_o,
	output logic [PRF_IDX_W-1:0] dest_tag_o,
	output logic [ROB_IDX_W-1:0] rob_idx_o,
	output logic                 done_o
);
	import fu_pkg::*;

	alu_func_e   func;
	logic [5:0]  shamt;
	logic [63:0] result;

	assign func  = alu_func_e'(inst_i[7:5]);
	assign shamt = opb_i[5:0];

	always_comb begin
		case (func)
			ADD:   result = opa_i + opb_i;
			SUB:   result = opa_i - opb_i;
			AND:   result = opa_i & opb_i;
			OR:    result = opa_i | opb_i;
			XOR:   result = opa_i ^ opb_i;
			SLL:   result = opa_i << shamt;
			SRL:   result = opa_i >> shamt;
			// signed compare, result is 0 or 1
			CMPLT: result = {63'b0, $signed(opa_i) < $signed(opb_i)};
			default: result = '0;
		endcase
	end

	// valid bit, dropped on recovery
	always_ff @(posedge clk) begin
		if (rst || recovery_i) begin
			done_o <= 1'b0;
		end else begin
			done_o <= start_i;
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			result_o   <= result;
			dest_tag_o <= dest_tag_i;
			rob_idx_o  <= rob_idx_i;
		end
	end

endmodule

// File: hdl/fu_main.sv
module fu_main #(
	parameter int ROB_IDX_W = fu_pkg::DEF_ROB_IDX_W,
	parameter int PRF_IDX_W = fu_pkg::DEF_PRF_IDX_W
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 iss_vld_i,
	input  fu_pkg::fu_sel_e      fu_sel_i,
	input  logic                 recovery_i,
	input  logic                 alu_done_i,
	input  logic [63:0]          alu_result_i,
	input  logic [PRF_IDX_W-1:0] alu_tag_i,
	input  logic [ROB_IDX_W-1:0] alu_rob_i,
	input  logic                 mult_done_i,
	input  logic [63:0]          mult_result_i,
	input  logic [PRF_IDX_W-1:0] mult_tag_i,
	input  logic [ROB_IDX_W-1:0] mult_rob_i,
	input  logic                 br_done_i,
	input  logic                 br_taken_i,
	input  logic [63:0]          br_target_i,
	input  logic [63:0]          br_pc_i,
	input  logic [ROB_IDX_W-1:0] br_rob_i,
	output logic                 alu_start_o,
	output logic                 br_start_o,
	output logic                 mult_start_o,
	output logic                 mult_stall_o,
	output logic                 cdb_vld_o,
	output logic [PRF_IDX_W-1:0] cdb_tag_o,
	output logic [63:0]          cdb_value_o,
	output logic                 rob_done_o,
	output logic [ROB_IDX_W-1:0] rob_idx_o,
	output logic                 rob_br_taken_o,
	output logic [63:0]          rob_br_target_o,
	output logic                 bp_done_o,
	output logic [63:0]          bp_pc_o,
	output logic                 bp_taken_o
);
	import fu_pkg::*;

	logic mult_win;
	logic cdb_req;

	// one start strobe per issue, same cycle
	always_comb begin
		alu_start_o  = 1'b0;
		br_start_o   = 1'b0;
		mult_start_o = 1'b0;
		if (iss_vld_i) begin
			case (fu_sel_i)
				FU_SEL_ALU:  alu_start_o  = 1'b1;
				FU_SEL_BR:   br_start_o   = 1'b1;
				FU_SEL_MULT: mult_start_o = 1'b1;
				default:     ;
			endcase
		end
	end

	// mult holds its last stage while alu owns the cdb or branch owns the rob port
	assign mult_stall_o = mult_done_i & (alu_done_i | br_done_i);
	assign mult_win     = mult_done_i & ~mult_stall_o;

	// cdb: alu first, then an unstalled mult result
	always_comb begin
		if (alu_done_i) begin
			cdb_req     = 1'b1;
			cdb_tag_o   = alu_tag_i;
			cdb_value_o = alu_result_i;
		end else if (mult_win) begin
			cdb_req     = 1'b1;
			cdb_tag_o   = mult_tag_i;
			cdb_value_o = mult_result_i;
		end else begin
			cdb_req     = 1'b0;
			cdb_tag_o   = '0;
			cdb_value_o = '0;
		end
	end

	// tag 0 has no destination; nothing is written during recovery
	assign cdb_vld_o = cdb_req & (cdb_tag_o != '0) & ~recovery_i;

	// rob port, branch > alu > mult
	assign rob_done_o = br_done_i | alu_done_i | mult_done_i;
	always_comb begin
		if (br_done_i)
			rob_idx_o = br_rob_i;
		else if (alu_done_i)
			rob_idx_o = alu_rob_i;
		else if (mult_done_i)
			rob_idx_o = mult_rob_i;
		else
			rob_idx_o = '0;
	end

	assign rob_br_taken_o  = br_done_i & br_taken_i;
	assign rob_br_target_o = br_target_i;

	// predictor update
	assign bp_done_o  = br_done_i;
	assign bp_pc_o    = br_pc_i;
	assign bp_taken_o = br_done_i & br_taken_i;

endmodule

// File: hdl/fu_pkg.sv
package fu_pkg;

	// functional unit picked by the reservation station at issue
	typedef enum logic [2:0] {
		FU_SEL_NONE = 3'd0,
		FU_SEL_ALU  = 3'd1,
		FU_SEL_BR   = 3'd2,
		FU_SEL_MULT = 3'd3
	} fu_sel_e;

	// alu operation, instruction bits 7:5
	typedef enum logic [2:0] {
		ADD   = 3'd0,
		SUB   = 3'd1,
		AND   = 3'd2,
		OR    = 3'd3,
		XOR   = 3'd4,
		SLL   = 3'd5,
		SRL   = 3'd6,
		CMPLT = 3'd7
	} alu_func_e;

	// branch condition on operand a, instruction bits 28:26
	// codes 5 to 7 are unused and resolve not taken
	typedef enum logic [2:0] {
		BR_ALWAYS = 3'd0,
		BR_EQZ    = 3'd1,
		BR_NEZ    = 3'd2,
		BR_LTZ    = 3'd3,
		BR_GEZ    = 3'd4
	} br_cond_e;

	// fixed instruction fields, decoded in the units:
	//   branch displacement is inst[20:0], sign extended, times 4
	//   register tag 0 is "no destination", never written on the cdb

	// default widths, overridden from the top level
	localparam int DEF_ROB_IDX_W   = 5;
	localparam int DEF_PRF_IDX_W   = 6;

	// must divide 64 and be at least 2
	localparam int DEF_MULT_STAGES = 4;

endpackage
